// ==== rvc_macros.svh ====
`ifndef RVC_MACROS_SVH
`define RVC_MACROS_SVH

// instruction and pc width, and the compressed half width.
`define RVC_XLEN 32
`define RVC_HALF 16

// addi x0, x0, 0 is presented during a bubble.
`define RVC_NOP 32'h0000_0013
`define RVC_ILLEGAL 32'h0000_0000
`define RVC_EBREAK 32'h0010_0073

// rv32i major opcodes used by the expansion.
`define RVC_OPC_LOAD 7'b0000011
`define RVC_OPC_STORE 7'b0100011
`define RVC_OPC_OP_IMM 7'b0010011
`define RVC_OPC_OP 7'b0110011
`define RVC_OPC_LUI 7'b0110111
`define RVC_OPC_JAL 7'b1101111
`define RVC_OPC_JALR 7'b1100111
`define RVC_OPC_BRANCH 7'b1100011

`endif

// ==== rvc_pkg.sv ====
package rvc_pkg;

  // how the current fetch word is laid out.
  typedef struct packed {
    logic f1f1;
    logic f1f2;
    logic fh;
    logic hf;
    logic hh;
  } fetch_class_t;

  // datapath selects from the control block.
  typedef struct packed {
    logic span;
    logic half_hi;
    logic full;
    logic bubble;
  } align_sel_t;

  //////////////////////////////////////////////////////////////
  // rvc formats, msb first, quadrant in the low two bits.
  //////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [2:0] funct3;
    logic       b12;
    logic [4:0] rd_rs1;
    logic [4:0] rs2;
    logic [1:0] op;
  } rvc_cr_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [4:0] rd_rs1;
    logic [4:0] imm_lo;
    logic [1:0] op;
  } rvc_ci_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [5:0] imm;
    logic [4:0] rs2;
    logic [1:0] op;
  } rvc_css_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;
    logic [2:0] rd_p;
    logic [1:0] op;
  } rvc_ciw_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rd_p;
    logic [1:0] op;
  } rvc_cl_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rs2_p;
    logic [1:0] op;
  } rvc_cs_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] off_hi;
    logic [2:0] rs1_p;
    logic [4:0] off_lo;
    logic [1:0] op;
  } rvc_cb_t;

  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;
    logic [1:0]  op;
  } rvc_cj_t;

  typedef union packed {
    rvc_cr_t  cr;
    rvc_ci_t  ci;
    rvc_css_t css;
    rvc_ciw_t ciw;
    rvc_cl_t  cl;
    rvc_cs_t  cs;
    rvc_cb_t  cb;
    rvc_cj_t  cj;
  } rvc_word_u;

endpackage

// ==== align_control.sv ====
`timescale 1ns/100ps

module align_control (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ff_en,
  input  logic                  clear_state,
  input  logic                  pc_half,
  input  logic [1:0]            lo_bits,
  input  logic [1:0]            hi_bits,
  output rvc_pkg::align_sel_t   sel,
  output rvc_pkg::fetch_class_t fclass,
  output logic                  stall_compressed,
  output logic                  hw_jump_clr,
  output logic                  sel_half_full
);

  logic pending_span;
  logic stall_ff;
  logic span;
  logic lo_full;
  logic hi_full;
  logic pair;

  assign lo_full = (lo_bits == 2'b11);
  assign hi_full = (hi_bits == 2'b11);

  // a flush wins over the pending upper half.
  assign span = pending_span & ~clear_state;
  assign pair = ~pc_half & ~lo_full & ~hi_full;

  always_comb begin
    fclass.f1f2 = span & hi_full;
    fclass.fh   = span & ~hi_full;
    fclass.f1f1 = ~span & ~pc_half & ~stall_ff & lo_full;
    fclass.hf   = ~span & ~pc_half & ~stall_ff & ~lo_full & hi_full;
    // second cycle of a split word counts as hh too.
    fclass.hh   = ~span & (stall_ff | pair);
  end

  assign hw_jump_clr      = ~span & pc_half & hi_full;
  assign stall_compressed = ~stall_ff & (fclass.fh | fclass.hh);

  always_comb begin
    sel.span    = span;
    sel.half_hi = pc_half | stall_ff;
    sel.full    = span | fclass.f1f1;
    sel.bubble  = hw_jump_clr;
  end

  assign sel_half_full = sel.full;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending_span <= 1'b0;
      stall_ff     <= 1'b0;
    end else if (ff_en) begin
      if (clear_state) begin
        pending_span <= 1'b0;
        stall_ff     <= 1'b0;
      end else begin
        pending_span <= hw_jump_clr | fclass.f1f2;
        stall_ff     <= stall_compressed;
      end
    end
  end

endmodule

// ==== fetch_aligner.sv ====
`timescale 1ns/100ps
`include "rvc_macros.svh"

module fetch_aligner (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ff_en,
  input  logic                  stall_compressed,
  input  rvc_pkg::align_sel_t   sel,
  input  logic [`RVC_XLEN-1:0]  inst_current,
  input  logic [`RVC_XLEN-1:0]  inst_exp,
  output logic [`RVC_HALF-1:0]  half_inst,
  output logic [`RVC_XLEN-1:0]  inst_id
);

  logic [`RVC_XLEN-1:0] inst_prev;
  logic [`RVC_XLEN-1:0] inst_span;

  // the word is held while a compressed pair is split.
  always_ff @(posedge clk) begin
    if (reset) begin
      inst_prev <= '0;
    end else if (ff_en && !stall_compressed) begin
      inst_prev <= inst_current;
    end
  end

  // low half of this word completes the upper half of the last one.
  assign inst_span = {inst_current[15:0], inst_prev[31:16]};

  assign half_inst = sel.half_hi ? inst_current[31:16] : inst_current[15:0];

  always_comb begin
    if (sel.bubble) begin
      inst_id = `RVC_NOP;
    end else if (sel.span) begin
      inst_id = inst_span;
    end else if (sel.full) begin
      inst_id = inst_current;
    end else begin
      inst_id = inst_exp;
    end
  end

endmodule

// ==== rvc_expander.sv ====
`timescale 1ns/100ps
`include "rvc_macros.svh"

module rvc_expander (
  input  logic [`RVC_HALF-1:0] half_inst,
  output logic [`RVC_XLEN-1:0] inst_exp
);

  rvc_pkg::rvc_word_u c;
  logic [4:0]  rdp;
  logic [4:0]  rs1p;
  logic [4:0]  rs2p;
  logic [5:0]  imm6;
  logic [9:0]  nzuimm;
  logic [9:0]  nzimm_sp;
  logic [6:0]  uimm_w;
  logic [10:0] j_off;
  logic [7:0]  b_off;
  logic [7:0]  lwsp_off;
  logic [7:0]  swsp_off;

  assign c = half_inst;

  // primed registers map onto x8..x15.
  assign rdp  = {2'b01, c.cl.rd_p};
  assign rs1p = {2'b01, c.cl.rs1_p};
  assign rs2p = {2'b01, c.cs.rs2_p};

  assign imm6     = {c.ci.imm_hi, c.ci.imm_lo};
  assign nzuimm   = {c.ciw.imm[5:2], c.ciw.imm[7:6], c.ciw.imm[0], c.ciw.imm[1], 2'b00};
  assign nzimm_sp = {c.ci.imm_hi, c.ci.imm_lo[2:1], c.ci.imm_lo[3], c.ci.imm_lo[0],
                     c.ci.imm_lo[4], 4'b0000};
  assign uimm_w   = {c.cl.imm_lo[0], c.cl.imm_hi, c.cl.imm_lo[1], 2'b00};
  // offset bits 11:1, bit 0 is always zero.
  assign j_off    = {c.cj.target[10], c.cj.target[6], c.cj.target[8:7], c.cj.target[4],
                     c.cj.target[5], c.cj.target[0], c.cj.target[9], c.cj.target[3:1]};
  assign b_off    = {c.cb.off_hi[2], c.cb.off_lo[4:3], c.cb.off_lo[0], c.cb.off_hi[1:0],
                     c.cb.off_lo[2:1]};
  assign lwsp_off = {c.ci.imm_lo[1:0], c.ci.imm_hi, c.ci.imm_lo[4:2], 2'b00};
  assign swsp_off = {c.css.imm[1:0], c.css.imm[5:2], 2'b00};

  always_comb begin
    inst_exp = `RVC_ILLEGAL;
    case ({c.cr.op, c.cr.funct3})
      //////////////////////////////////////////////////////////////
      // quadrant 0.
      5'b00_000: if (c.ciw.imm != 8'd0)
        inst_exp = {2'b00, nzuimm, 5'd2, 3'b000, rdp, `RVC_OPC_OP_IMM};
      5'b00_010: inst_exp = {5'd0, uimm_w, rs1p, 3'b010, rdp, `RVC_OPC_LOAD};
      5'b00_110:
        inst_exp = {5'd0, uimm_w[6:5], rs2p, rs1p, 3'b010, uimm_w[4:0], `RVC_OPC_STORE};
      //////////////////////////////////////////////////////////////
      // quadrant 1.
      5'b01_000: inst_exp = {{6{imm6[5]}}, imm6, c.ci.rd_rs1, 3'b000, c.ci.rd_rs1,
                             `RVC_OPC_OP_IMM};
      5'b01_001: inst_exp = {j_off[10], j_off[9:0], j_off[10], {8{j_off[10]}}, 5'd1,
                             `RVC_OPC_JAL};
      5'b01_010: inst_exp = {{6{imm6[5]}}, imm6, 5'd0, 3'b000, c.ci.rd_rs1, `RVC_OPC_OP_IMM};
      5'b01_011: begin
        if (c.ci.rd_rs1 == 5'd2) begin
          if (imm6 != 6'd0)
            inst_exp = {{2{nzimm_sp[9]}}, nzimm_sp, 5'd2, 3'b000, 5'd2, `RVC_OPC_OP_IMM};
        end else if (imm6 != 6'd0) begin
          inst_exp = {{14{imm6[5]}}, imm6, c.ci.rd_rs1, `RVC_OPC_LUI};
        end
      end
      5'b01_100: begin
        case (c.cb.off_hi[1:0])
          2'b00: if (!c.cb.off_hi[2])
            inst_exp = {7'b0000000, c.cb.off_lo, rs1p, 3'b101, rs1p, `RVC_OPC_OP_IMM};
          2'b01: if (!c.cb.off_hi[2])
            inst_exp = {7'b0100000, c.cb.off_lo, rs1p, 3'b101, rs1p, `RVC_OPC_OP_IMM};
          2'b10: inst_exp = {{6{imm6[5]}}, imm6, rs1p, 3'b111, rs1p, `RVC_OPC_OP_IMM};
          default: begin
            // bit 12 set is the rv64 word group.
            if (!c.cb.off_hi[2]) begin
              case (c.cs.imm_lo)
                2'b00: inst_exp = {7'b0100000, rs2p, rs1p, 3'b000, rs1p, `RVC_OPC_OP};
                2'b01: inst_exp = {7'b0000000, rs2p, rs1p, 3'b100, rs1p, `RVC_OPC_OP};
                2'b10: inst_exp = {7'b0000000, rs2p, rs1p, 3'b110, rs1p, `RVC_OPC_OP};
                default: inst_exp = {7'b0000000, rs2p, rs1p, 3'b111, rs1p, `RVC_OPC_OP};
              endcase
            end
          end
        endcase
      end
      5'b01_101: inst_exp = {j_off[10], j_off[9:0], j_off[10], {8{j_off[10]}}, 5'd0,
                             `RVC_OPC_JAL};
      5'b01_110: inst_exp = {b_off[7], {2{b_off[7]}}, b_off[7:4], 5'd0, rs1p, 3'b000,
                             b_off[3:0], b_off[7], `RVC_OPC_BRANCH};
      5'b01_111: inst_exp = {b_off[7], {2{b_off[7]}}, b_off[7:4], 5'd0, rs1p, 3'b001,
                             b_off[3:0], b_off[7], `RVC_OPC_BRANCH};
      //////////////////////////////////////////////////////////////
      // quadrant 2.
      5'b10_000: if (!imm6[5])
        inst_exp = {7'b0000000, imm6[4:0], c.ci.rd_rs1, 3'b001, c.ci.rd_rs1, `RVC_OPC_OP_IMM};
      5'b10_010: if (c.ci.rd_rs1 != 5'd0)
        inst_exp = {4'd0, lwsp_off, 5'd2, 3'b010, c.ci.rd_rs1, `RVC_OPC_LOAD};
      5'b10_100: begin
        if (!c.cr.b12) begin
          if (c.cr.rs2 != 5'd0)
            inst_exp = {7'b0000000, c.cr.rs2, 5'd0, 3'b000, c.cr.rd_rs1, `RVC_OPC_OP};
          else if (c.cr.rd_rs1 != 5'd0)
            inst_exp = {12'd0, c.cr.rd_rs1, 3'b000, 5'd0, `RVC_OPC_JALR};
        end else if (c.cr.rs2 != 5'd0) begin
          inst_exp = {7'b0000000, c.cr.rs2, c.cr.rd_rs1, 3'b000, c.cr.rd_rs1, `RVC_OPC_OP};
        end else if (c.cr.rd_rs1 == 5'd0) begin
          inst_exp = `RVC_EBREAK;
        end else begin
          inst_exp = {12'd0, c.cr.rd_rs1, 3'b000, 5'd1, `RVC_OPC_JALR};
        end
      end
      5'b10_110: inst_exp = {4'd0, swsp_off[7:5], c.css.rs2, 5'd2, 3'b010, swsp_off[4:0],
                             `RVC_OPC_STORE};
      default: inst_exp = `RVC_ILLEGAL;
    endcase
  end

endmodule

// ==== pc_corrector.sv ====
`timescale 1ns/100ps
`include "rvc_macros.svh"

module pc_corrector (
  input  logic [`RVC_XLEN-1:0]  pc,
  input  rvc_pkg::fetch_class_t fclass,
  input  logic                  stall_compressed,
  input  logic                  span,
  output logic [`RVC_XLEN-1:0]  corrected_pc
);

  // fetch already points at the word after the start of a spanning
  // instruction, and holds the pc while a pair is split.
  always_comb begin
    if (span) begin
      corrected_pc = pc - 32'd2;
    end else if (fclass.hh && !stall_compressed) begin
      corrected_pc = pc + 32'd2;
    end else begin
      corrected_pc = pc;
    end
  end

endmodule

// ==== pre_decode.sv ====
`timescale 1ns/100ps
`include "rvc_macros.svh"

module pre_decode (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [`RVC_XLEN-1:0] current_pc_id,
  input  logic [`RVC_XLEN-1:0] inst_current,
  input  logic                 clear_state,
  input  logic                 ff_en,
  output logic [`RVC_XLEN-1:0] inst_id,
  output logic                 stall_compressed,
  output logic [`RVC_XLEN-1:0] corrected_pc,
  output logic                 hw_jump_clr,
  output logic                 sel_half_full
);

  rvc_pkg::align_sel_t   sel;
  rvc_pkg::fetch_class_t fclass;
  logic [`RVC_HALF-1:0]  half_inst;
  logic [`RVC_XLEN-1:0]  inst_exp;

  align_control align_control_i (
    .clk              (clk),
    .reset            (reset),
    .ff_en            (ff_en),
    .clear_state      (clear_state),
    .pc_half          (current_pc_id[1]),
    .lo_bits          (inst_current[1:0]),
    .hi_bits          (inst_current[17:16]),
    .sel              (sel),
    .fclass           (fclass),
    .stall_compressed (stall_compressed),
    .hw_jump_clr      (hw_jump_clr),
    .sel_half_full    (sel_half_full)
  );

  fetch_aligner fetch_aligner_i (
    .clk              (clk),
    .reset            (reset),
    .ff_en            (ff_en),
    .stall_compressed (stall_compressed),
    .sel              (sel),
    .inst_current     (inst_current),
    .inst_exp         (inst_exp),
    .half_inst        (half_inst),
    .inst_id          (inst_id)
  );

  rvc_expander rvc_expander_i (
    .half_inst (half_inst),
    .inst_exp  (inst_exp)
  );

  pc_corrector pc_corrector_i (
    .pc               (current_pc_id),
    .fclass           (fclass),
    .stall_compressed (stall_compressed),
    .span             (sel.span),
    .corrected_pc     (corrected_pc)
  );

endmodule

// ==== pre_decode_sva.sv ====
`timescale 1ns/100ps

module pre_decode_sva (
  input logic clk,
  input logic reset,
  input logic ff_en,
  input logic clear_state,
  input logic stall_compressed,
  input logic hw_jump_clr,
  input logic pending_span
);

  int fail_count = 0;

  // a split pair stalls fetch for one enabled cycle only.
  stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
    (ff_en && stall_compressed) |=> !stall_compressed)
    else begin
      fail_count++;
      $error("stall_compressed high for two enabled cycles");
    end

  // an odd-halfword full start leaves its upper half pending.
  jump_sets_pending: assert property (@(posedge clk) disable iff (reset)
    (ff_en && hw_jump_clr && !clear_state) |=> pending_span)
    else begin
      fail_count++;
      $error("hw_jump_clr did not set pending_span");
    end

  clear_drops_pending: assert property (@(posedge clk) disable iff (reset)
    (ff_en && clear_state) |=> !pending_span)
    else begin
      fail_count++;
      $error("pending_span survived clear_state");
    end

endmodule

// ==== tb_pre_decode.sv ====
`timescale 1ns/100ps
`include "rvc_macros.svh"

module tb_pre_decode;

  logic        clk;
  logic        reset;
  logic [31:0] current_pc_id;
  logic [31:0] inst_current;
  logic        clear_state;
  logic        ff_en;
  logic [31:0] inst_id;
  logic        stall_compressed;
  logic [31:0] corrected_pc;
  logic        hw_jump_clr;
  logic        sel_half_full;

  // each entry holds a compressed word above its rv32i expansion.
  localparam logic [47:0] expand_table [15] = '{
    48'h0085_0010_8093, 48'h557D_FFF0_0513, 48'h852E_00B0_0533, 48'h952E_00B5_0533,
    48'h40C0_0044_A403, 48'hC206_0011_2223, 48'h0040_0041_0413, 48'h2021_0080_00EF,
    48'hBFFD_FFFF_F06F, 48'hC401_0004_0463, 48'h8C89_40A4_84B3, 48'h9002_0010_0073,
    48'h0000_0000_0000, 48'h6000_0000_0000, 48'h6081_0000_0000
  };

  pre_decode pre_decode_i (.*);

  bind align_control pre_decode_sva pre_decode_sva_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("error at time %0t: %s", $time, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  function automatic logic [15:0] filler();
    logic [31:0] r;
    r = $urandom;
    return r[15:0];
  endfunction

  // inputs change on the falling edge and outputs are sampled 10 ns later.
  task automatic drive(input logic [31:0] pc, input logic [31:0] word, input logic en,
                       input logic clr);
    @(negedge clk);
    current_pc_id = pc;
    inst_current  = word;
    ff_en         = en;
    clear_state   = clr;
    #10;
  endtask

  task automatic wait_stall_release(input int limit);
    int cycles;
    cycles = 0;
    while (stall_compressed && cycles < limit) begin
      @(negedge clk);
      #10;
      cycles++;
    end
    if (stall_compressed) begin
      $display("timeout: stall_compressed still high after %0d cycles", limit);
      $display("Simulation finished: FAIL");
      $fatal(1, "stall did not release");
    end
  endtask

  task automatic check_outputs(input string what, input logic [31:0] exp_inst,
                               input logic [31:0] exp_pc, input logic exp_full,
                               input logic exp_stall, input logic exp_jump);
    assert (inst_id === exp_inst)
      else report_error($sformatf("%s: inst_id %h, expected %h", what, inst_id, exp_inst));
    assert (corrected_pc === exp_pc)
      else report_error($sformatf("%s: corrected_pc %h, expected %h", what,
                                  corrected_pc, exp_pc));
    assert (sel_half_full === exp_full)
      else report_error($sformatf("%s: sel_half_full %b, expected %b", what,
                                  sel_half_full, exp_full));
    assert (stall_compressed === exp_stall)
      else report_error($sformatf("%s: stall_compressed %b, expected %b", what,
                                  stall_compressed, exp_stall));
    assert (hw_jump_clr === exp_jump)
      else report_error($sformatf("%s: hw_jump_clr %b, expected %b", what,
                                  hw_jump_clr, exp_jump));
  endtask

  // fetch holds word and pc until the second compressed half is taken.
  task automatic check_pair(input logic [31:0] pc, input logic [31:0] word,
                            input logic [31:0] exp_lo, input logic [31:0] exp_hi);
    drive(pc, word, 1'b1, 1'b0);
    check_outputs("pair low half", exp_lo, pc, 1'b0, 1'b1, 1'b0);
    drive(pc, word, 1'b1, 1'b0);
    wait_stall_release(4);
    check_outputs("pair high half", exp_hi, pc + 32'd2, 1'b0, 1'b0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests.
  ////////////////////////////////////////////////////////////
  task automatic test_full_word();
    logic [31:0] word;
    logic [31:0] pc;
    for (int i = 0; i < 4; i++) begin
      word = $urandom | 32'h3;
      pc   = 32'h0000_0100 + 32'(i) * 4;
      drive(pc, word, 1'b1, 1'b0);
      check_outputs("full word", word, pc, 1'b1, 1'b0, 1'b0);
    end
  endtask

  task automatic test_expansion();
    logic [31:0] pc;
    logic [3:0]  idx;
    for (int i = 0; i < 15; i++) begin
      idx = 4'(i);
      pc  = 32'h0000_1002 + 32'(i) * 4;
      drive(pc, {expand_table[idx][47:32], filler()}, 1'b1, 1'b0);
      check_outputs($sformatf("expansion of %h", expand_table[idx][47:32]),
                    expand_table[idx][31:0], pc, 1'b0, 1'b0, 1'b0);
    end
  endtask

  task automatic test_pair();
    check_pair(32'h0000_2000, 32'h0085_557D, 32'hFFF0_0513, 32'h0010_8093);
    check_pair(32'h0000_2008, 32'h8C89_852E, 32'h00B0_0533, 32'h40A4_84B3);
  endtask

  // add x10, x11, x12 split over two words and followed by c.addi x1, 1.
  task automatic test_spanning();
    drive(32'h0000_3002, {16'h8533, filler()}, 1'b1, 1'b0);
    check_outputs("span start", `RVC_NOP, 32'h0000_3002, 1'b0, 1'b0, 1'b1);
    drive(32'h0000_3004, 32'h0085_00C5, 1'b1, 1'b0);
    check_outputs("span join", 32'h00C5_8533, 32'h0000_3002, 1'b1, 1'b1, 1'b0);
    drive(32'h0000_3004, 32'h0085_00C5, 1'b1, 1'b0);
    check_outputs("half after span", 32'h0010_8093, 32'h0000_3006, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic test_hold_and_flush();
    drive(32'h0000_4002, {16'h8533, filler()}, 1'b1, 1'b0);
    check_outputs("hold start", `RVC_NOP, 32'h0000_4002, 1'b0, 1'b0, 1'b1);
    repeat (3) begin
      drive(32'h0000_4004, 32'h0085_00C5, 1'b0, 1'b0);
      check_outputs("held span", 32'h00C5_8533, 32'h0000_4002, 1'b1, 1'b1, 1'b0);
    end
    // the flush word and the pair after it must not join the old half.
    drive(32'h0000_5000, 32'h00A0_0093, 1'b1, 1'b1);
    check_outputs("flush", 32'h00A0_0093, 32'h0000_5000, 1'b1, 1'b0, 1'b0);
    check_pair(32'h0000_5004, 32'h0085_557D, 32'hFFF0_0513, 32'h0010_8093);
  endtask

  initial begin
    void'($urandom(32'h9e09_8fd5));
    reset         = 1'b1;
    ff_en         = 1'b0;
    clear_state   = 1'b0;
    current_pc_id = '0;
    inst_current  = `RVC_NOP;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    test_full_word();
    test_expansion();
    test_pair();
    test_spanning();
    test_hold_and_flush();
    // one more edge so the bound assertions see the last enabled cycle.
    @(negedge clk);
    if (pre_decode_i.align_control_i.pre_decode_sva_i.fail_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("bound assertions failed %0d times",
               pre_decode_i.align_control_i.pre_decode_sva_i.fail_count);
      $display("Simulation finished: FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

// ==== compile.f ====
+incdir+.
rvc_pkg.sv
align_control.sv
fetch_aligner.sv
rvc_expander.sv
pc_corrector.sv
pre_decode.sv
pre_decode_sva.sv
tb_pre_decode.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = tb_pre_decode
FILELIST   = compile.f
LOG        = sim.log
FAIL_MSG   = Simulation finished: FAIL
PASS_MSG   = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
